//--- design/fm_reg_settings.svh
`ifndef FM_REG_SETTINGS_SVH
`define FM_REG_SETTINGS_SVH

// three channels per part, two parts
`define FM_NUM_CH 6

// four operators per channel
`define FM_NUM_SLOTS 24

// packed operator word, one per slot
`define FM_OP_W 40

// tl of 127 is full attenuation
`define FM_TL_RESET 7'd127

// left and right outputs both on
`define FM_RL_RESET 2'b11

`endif

//--- design/fm_bus_pkg.sv
package fm_bus_pkg;

	// register group of a host write, named after its address row
	typedef enum logic [3:0] {
		GRP_DT_MUL,      // 0x30
		GRP_TL,          // 0x40
		GRP_KS_AR,       // 0x50
		GRP_AM_D1R,      // 0x60
		GRP_D2R,         // 0x70
		GRP_D1L_RR,      // 0x80
		GRP_FNUM_LO,     // 0xa0
		GRP_BLK_FNHI,    // 0xa4
		GRP_FB_ALG,      // 0xb0
		GRP_LR_AMS_PMS,  // 0xb4
		GRP_NONE
	} reg_group_e;

	// four-phase req/ack sequence
	typedef enum logic [1:0] {
		IDLE,
		WAIT_SLOT,
		ACK_HIGH,
		WAIT_REQ_LOW
	} bus_state_e;

endpackage

//--- design/fm_voice_pkg.sv
package fm_voice_pkg;

	// operator stages in slot order, same as address bits 3:2
	typedef enum logic [1:0] {
		S1 = 2'd0,
		S3 = 2'd1,
		S2 = 2'd2,
		S4 = 2'd3
	} op_stage_e;

	// connection algorithm 0 to 7
	typedef logic [2:0] alg_t;

endpackage

//--- design/fm_bus_port.sv
`timescale 1ns/1ps

module fm_bus_port
	import fm_bus_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       req,
	input  logic [7:0] addr,
	input  logic       part,
	input  logic [7:0] data,
	output logic       ack,
	input  logic       op_done,
	input  logic       ch_done,
	output logic       wr_pending,
	output reg_group_e wr_group,
	output logic [2:0] wr_ch,
	output logic [1:0] wr_op,
	output logic [7:0] wr_data
);

	bus_state_e state;
	reg_group_e grp_dec;
	logic       wr_valid;

	// address row to register group
	always_comb begin
		case (addr[7:4])
			4'h3: grp_dec = GRP_DT_MUL;
			4'h4: grp_dec = GRP_TL;
			4'h5: grp_dec = GRP_KS_AR;
			4'h6: grp_dec = GRP_AM_D1R;
			4'h7: grp_dec = GRP_D2R;
			4'h8: grp_dec = GRP_D1L_RR;
			// 0xa8 and 0xac are ch3 special mode, not kept
			4'hA: grp_dec = (addr[3:2] == 2'd0) ? GRP_FNUM_LO :
				(addr[3:2] == 2'd1) ? GRP_BLK_FNHI : GRP_NONE;
			4'hB: grp_dec = (addr[3:2] == 2'd0) ? GRP_FB_ALG :
				(addr[3:2] == 2'd1) ? GRP_LR_AMS_PMS : GRP_NONE;
			// ssg-eg row and below
			default: grp_dec = GRP_NONE;
		endcase
	end

	// channel field 3 addresses nothing in either part
	assign wr_valid = (grp_dec != GRP_NONE) && (addr[1:0] != 2'd3);

	// payload captured once per write, stable while pending
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			wr_group <= grp_dec;
			// part picks channel codes 0-2 or 4-6
			wr_ch    <= {part, addr[1:0]};
			wr_op    <= addr[3:2];
			wr_data  <= data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			ack        <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						// bad writes skip the slot wait
						wr_pending <= wr_valid;
						state      <= WAIT_SLOT;
					end
				end
				WAIT_SLOT: begin
					// done pulse comes from the memory that took the write
					if (!wr_pending || op_done || ch_done) begin
						wr_pending <= 1'b0;
						ack        <= 1'b1;
						state      <= ACK_HIGH;
					end
				end
				ACK_HIGH, WAIT_REQ_LOW: begin
					// host holding req keeps ack up, nothing new accepted
					if (!req) begin
						ack   <= 1'b0;
						state <= IDLE;
					end else begin
						state <= WAIT_REQ_LOW;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- design/fm_slot_counter.sv
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_slot_counter
	import fm_voice_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      clk_en,
	output logic [2:0] cur_ch,
	output logic [1:0] cur_op,
	output logic [2:0] next_ch,
	output logic [1:0] next_op,
	output op_stage_e stage,
	output logic      zero
);

	// linear slot number, 0 at op 0 ch 0
	logic [4:0] slot_idx;
	logic [4:0] next_idx;

	always_comb begin
		// channel code 2 jumps to 4, 6 wraps to 0
		next_ch = (cur_ch[1:0] == 2'd2) ? cur_ch + 3'd2 : cur_ch + 3'd1;
		// operator row steps after the last channel
		next_op = (cur_ch == 3'd6) ? cur_op + 2'd1 : cur_op;
		next_idx = (slot_idx == `FM_NUM_SLOTS - 1) ? 5'd0 : slot_idx + 5'd1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cur_ch   <= 3'd0;
			cur_op   <= 2'd0;
			slot_idx <= 5'd0;
			// reset parks on slot 0
			zero     <= 1'b1;
		end else if (clk_en) begin
			cur_ch   <= next_ch;
			cur_op   <= next_op;
			slot_idx <= next_idx;
			zero     <= (next_idx == 5'd0);
		end
	end

	// address bit order is already s1 s3 s2 s4
	assign stage = op_stage_e'(cur_op);

endmodule

//--- design/fm_op_regs.sv
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_op_regs
	import fm_bus_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       clk_en,
	input  logic [2:0] cur_ch,
	input  logic [1:0] cur_op,
	input  logic       wr_pending,
	input  reg_group_e wr_group,
	input  logic [2:0] wr_ch,
	input  logic [1:0] wr_op,
	input  logic [7:0] wr_data,
	output logic       op_done,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic       am,
	output logic [4:0] d1r,
	output logic [4:0] d2r,
	output logic [3:0] d1l,
	output logic [3:0] rr
);

	logic [`FM_OP_W-1:0] mem [`FM_NUM_SLOTS];
	logic [`FM_OP_W-1:0] word_rd;
	logic [`FM_OP_W-1:0] word_wr;
	logic [2:0]          ch_idx;
	logic [4:0]          slot;
	logic                op_grp;
	logic                hit;

	// channel code 0-2,4-6 to 0-5
	assign ch_idx = cur_ch - {2'b00, cur_ch[2]};
	assign slot = cur_op * 5'(`FM_NUM_CH) + {2'b00, ch_idx};

	// word layout, msb first
	// tl 39:33, dt1 32:30, mul 29:26, ks 25:24, ar 23:19
	// am 18, d1r 17:13, d2r 12:8, d1l 7:4, rr 3:0
	assign word_rd = mem[slot];
	assign {tl, dt1, mul, ks, ar, am, d1r, d2r, d1l, rr} = word_rd;

	assign op_grp = wr_group inside {GRP_DT_MUL, GRP_TL, GRP_KS_AR,
		GRP_AM_D1R, GRP_D2R, GRP_D1L_RR};

	// done blocks a second commit while the port drops pending
	assign hit = wr_pending && clk_en && !op_done && op_grp &&
		(wr_op == cur_op) && (wr_ch == cur_ch);

	// only the fields of the written group change
	always_comb begin
		word_wr = word_rd;
		case (wr_group)
			GRP_DT_MUL: begin
				word_wr[32:30] = wr_data[6:4];
				word_wr[29:26] = wr_data[3:0];
			end
			GRP_TL: word_wr[39:33] = wr_data[6:0];
			GRP_KS_AR: begin
				word_wr[25:24] = wr_data[7:6];
				word_wr[23:19] = wr_data[4:0];
			end
			GRP_AM_D1R: begin
				word_wr[18]    = wr_data[7];
				word_wr[17:13] = wr_data[4:0];
			end
			GRP_D2R: word_wr[12:8] = wr_data[4:0];
			GRP_D1L_RR: begin
				word_wr[7:4] = wr_data[7:4];
				word_wr[3:0] = wr_data[3:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_done <= 1'b0;
			// full attenuation, everything else zero
			for (int i = 0; i < `FM_NUM_SLOTS; i++)
				mem[i] <= {`FM_TL_RESET, {(`FM_OP_W - 7){1'b0}}};
		end else begin
			op_done <= hit;
			if (hit)
				mem[slot] <= word_wr;
		end
	end

endmodule

//--- design/fm_ch_regs.sv
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_ch_regs
	import fm_bus_pkg::*;
	import fm_voice_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        clk_en,
	input  logic [2:0]  cur_ch,
	input  logic        wr_pending,
	input  reg_group_e  wr_group,
	input  logic [2:0]  wr_ch,
	input  logic [7:0]  wr_data,
	output logic        ch_done,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output alg_t        alg,
	output logic [1:0]  rl,
	output logic [1:0]  ams,
	output logic [2:0]  pms
);

	logic [10:0] fnum_m  [`FM_NUM_CH];
	logic [2:0]  block_m [`FM_NUM_CH];
	logic [2:0]  fb_m    [`FM_NUM_CH];
	alg_t        alg_m   [`FM_NUM_CH];
	logic [1:0]  rl_m    [`FM_NUM_CH];
	logic [1:0]  ams_m   [`FM_NUM_CH];
	logic [2:0]  pms_m   [`FM_NUM_CH];
	// block and fnum high wait here for the low byte
	logic [2:0]  blk_lat [`FM_NUM_CH];
	logic [2:0]  fhi_lat [`FM_NUM_CH];
	logic [2:0]  ch_idx;
	logic        ch_grp;
	logic        hit;

	assign ch_idx = cur_ch - {2'b00, cur_ch[2]};

	assign ch_grp = wr_group inside {GRP_FNUM_LO, GRP_BLK_FNHI,
		GRP_FB_ALG, GRP_LR_AMS_PMS};

	// any operator slot of the channel will do
	assign hit = wr_pending && clk_en && !ch_done && ch_grp && (wr_ch == cur_ch);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ch_done <= 1'b0;
			for (int i = 0; i < `FM_NUM_CH; i++) begin
				fnum_m[i]  <= 11'd0;
				block_m[i] <= 3'd0;
				fb_m[i]    <= 3'd0;
				alg_m[i]   <= 3'd0;
				rl_m[i]    <= `FM_RL_RESET;
				ams_m[i]   <= 2'd0;
				pms_m[i]   <= 3'd0;
				blk_lat[i] <= 3'd0;
				fhi_lat[i] <= 3'd0;
			end
		end else begin
			ch_done <= hit;
			if (hit) begin
				case (wr_group)
					// latch only, pitch unchanged
					GRP_BLK_FNHI: begin
						blk_lat[ch_idx] <= wr_data[5:3];
						fhi_lat[ch_idx] <= wr_data[2:0];
					end
					// low byte moves the whole pitch in at once
					GRP_FNUM_LO: begin
						fnum_m[ch_idx]  <= {fhi_lat[ch_idx], wr_data};
						block_m[ch_idx] <= blk_lat[ch_idx];
					end
					GRP_FB_ALG: begin
						fb_m[ch_idx]  <= wr_data[5:3];
						alg_m[ch_idx] <= wr_data[2:0];
					end
					GRP_LR_AMS_PMS: begin
						rl_m[ch_idx]  <= wr_data[7:6];
						ams_m[ch_idx] <= wr_data[5:4];
						pms_m[ch_idx] <= wr_data[2:0];
					end
					default: ;
				endcase
			end
		end
	end

	// current channel view
	assign fnum  = fnum_m[ch_idx];
	assign block = block_m[ch_idx];
	assign fb    = fb_m[ch_idx];
	assign alg   = alg_m[ch_idx];
	assign rl    = rl_m[ch_idx];
	assign ams   = ams_m[ch_idx];
	assign pms   = pms_m[ch_idx];

endmodule

//--- design/fm_slot_out.sv
`timescale 1ns/1ps

module fm_slot_out
	import fm_voice_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        clk_en,
	input  logic [2:0]  cur_dt1,
	input  logic [3:0]  cur_mul,
	input  logic [6:0]  cur_tl,
	input  logic [1:0]  cur_ks,
	input  logic [4:0]  cur_ar,
	input  logic        cur_am,
	input  logic [4:0]  cur_d1r,
	input  logic [4:0]  cur_d2r,
	input  logic [3:0]  cur_d1l,
	input  logic [3:0]  cur_rr,
	input  logic [10:0] cur_fnum,
	input  logic [2:0]  cur_block,
	input  logic [2:0]  cur_fb,
	input  alg_t        cur_alg,
	input  logic [1:0]  cur_rl,
	input  logic [1:0]  cur_ams,
	input  logic [2:0]  cur_pms,
	input  logic [2:0]  cur_ch,
	input  logic [1:0]  cur_op,
	input  op_stage_e   stage,
	input  logic        zero,
	output logic [2:0]  slot_ch,
	output logic [1:0]  slot_op,
	output logic        frame_start,
	output logic        carrier,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic        am,
	output logic [4:0]  d1r,
	output logic [4:0]  d2r,
	output logic [3:0]  d1l,
	output logic [3:0]  rr,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output alg_t        alg,
	output logic [1:0]  rl,
	output logic [1:0]  ams,
	output logic [2:0]  pms
);

	logic carrier_nx;

	// stages that reach the output for each algorithm
	always_comb begin
		case (cur_alg)
			3'd0, 3'd1, 3'd2, 3'd3: carrier_nx = (stage == S4);
			3'd4: carrier_nx = (stage == S2) || (stage == S4);
			3'd5, 3'd6: carrier_nx = (stage != S1);
			default: carrier_nx = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_ch     <= 3'd0;
			slot_op     <= 2'd0;
			frame_start <= 1'b0;
			carrier     <= 1'b0;
		end else if (clk_en) begin
			// drop the gap at code 3
			slot_ch     <= cur_ch - {2'b00, cur_ch[2]};
			slot_op     <= cur_op;
			frame_start <= zero;
			carrier     <= carrier_nx;
		end
	end

	// parameter payload
	always_ff @(posedge clk) begin
		if (clk_en) begin
			{dt1, mul, tl, ks, ar} <= {cur_dt1, cur_mul, cur_tl, cur_ks, cur_ar};
			{am, d1r, d2r, d1l, rr} <= {cur_am, cur_d1r, cur_d2r, cur_d1l, cur_rr};
			{fnum, block, fb, alg} <= {cur_fnum, cur_block, cur_fb, cur_alg};
			{rl, ams, pms} <= {cur_rl, cur_ams, cur_pms};
		end
	end

endmodule

//--- design/fm_reg_top.sv
`timescale 1ns/1ps

module fm_reg_top
	import fm_bus_pkg::*;
	import fm_voice_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        clk_en,
	input  logic        req,
	input  logic [7:0]  addr,
	input  logic        part,
	input  logic [7:0]  data,
	output logic        ack,
	output logic [2:0]  slot_ch,
	output logic [1:0]  slot_op,
	output logic        frame_start,
	output logic        carrier,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic        am,
	output logic [4:0]  d1r,
	output logic [4:0]  d2r,
	output logic [3:0]  d1l,
	output logic [3:0]  rr,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output alg_t        alg,
	output logic [1:0]  rl,
	output logic [1:0]  ams,
	output logic [2:0]  pms
);

	// pending write
	logic       wr_pending;
	reg_group_e wr_group;
	logic [2:0] wr_ch;
	logic [1:0] wr_op;
	logic [7:0] wr_data;
	logic       op_done;
	logic       ch_done;

	// slot position
	logic [2:0] cur_ch;
	logic [1:0] cur_op;
	op_stage_e  stage;
	logic       zero;

	// current slot parameters
	logic [2:0]  cur_dt1, cur_fb, cur_block, cur_pms;
	logic [3:0]  cur_mul, cur_d1l, cur_rr;
	logic [6:0]  cur_tl;
	logic [1:0]  cur_ks, cur_rl, cur_ams;
	logic [4:0]  cur_ar, cur_d1r, cur_d2r;
	logic        cur_am;
	logic [10:0] cur_fnum;
	alg_t        cur_alg;

	fm_bus_port u_bus_port (
		.clk(clk), .arst_n(arst_n), .req(req), .addr(addr), .part(part),
		.data(data), .ack(ack), .op_done(op_done), .ch_done(ch_done),
		.wr_pending(wr_pending), .wr_group(wr_group), .wr_ch(wr_ch),
		.wr_op(wr_op), .wr_data(wr_data)
	);

	// next-slot values are not needed outside the counter here
	fm_slot_counter u_slot_counter (
		.clk(clk), .arst_n(arst_n), .clk_en(clk_en), .cur_ch(cur_ch),
		.cur_op(cur_op), .next_ch(), .next_op(), .stage(stage), .zero(zero)
	);

	fm_op_regs u_op_regs (
		.clk(clk), .arst_n(arst_n), .clk_en(clk_en), .cur_ch(cur_ch), .cur_op(cur_op),
		.wr_pending(wr_pending), .wr_group(wr_group), .wr_ch(wr_ch), .wr_op(wr_op),
		.wr_data(wr_data), .op_done(op_done),
		.dt1(cur_dt1), .mul(cur_mul), .tl(cur_tl), .ks(cur_ks), .ar(cur_ar),
		.am(cur_am), .d1r(cur_d1r), .d2r(cur_d2r), .d1l(cur_d1l), .rr(cur_rr)
	);

	fm_ch_regs u_ch_regs (
		.clk(clk), .arst_n(arst_n), .clk_en(clk_en), .cur_ch(cur_ch),
		.wr_pending(wr_pending), .wr_group(wr_group), .wr_ch(wr_ch),
		.wr_data(wr_data), .ch_done(ch_done),
		.fnum(cur_fnum), .block(cur_block), .fb(cur_fb), .alg(cur_alg),
		.rl(cur_rl), .ams(cur_ams), .pms(cur_pms)
	);

	fm_slot_out u_slot_out (
		.clk(clk), .arst_n(arst_n), .clk_en(clk_en),
		.cur_dt1(cur_dt1), .cur_mul(cur_mul), .cur_tl(cur_tl), .cur_ks(cur_ks),
		.cur_ar(cur_ar), .cur_am(cur_am), .cur_d1r(cur_d1r), .cur_d2r(cur_d2r),
		.cur_d1l(cur_d1l), .cur_rr(cur_rr), .cur_fnum(cur_fnum),
		.cur_block(cur_block), .cur_fb(cur_fb), .cur_alg(cur_alg),
		.cur_rl(cur_rl), .cur_ams(cur_ams), .cur_pms(cur_pms),
		.cur_ch(cur_ch), .cur_op(cur_op), .stage(stage), .zero(zero),
		.slot_ch(slot_ch), .slot_op(slot_op), .frame_start(frame_start),
		.carrier(carrier), .dt1(dt1), .mul(mul), .tl(tl), .ks(ks), .ar(ar),
		.am(am), .d1r(d1r), .d2r(d2r), .d1l(d1l), .rr(rr), .fnum(fnum),
		.block(block), .fb(fb), .alg(alg), .rl(rl), .ams(ams), .pms(pms)
	);

endmodule

//--- sim/fm_reg_assertions.sv
`timescale 1ns/1ps

module fm_reg_assertions (
	input logic       clk,
	input logic       arst_n,
	input logic       req,
	input logic       ack,
	input logic [2:0] ch
);

	// ack only answers a live request
	ack_needs_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> req
	) else $error("ack rose while req was low");

	// release phase takes one clock
	ack_follows_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		$fell(req) |=> !ack
	) else $error("ack did not fall one cycle after req fell");

	// codes 3 and 7 are gaps in the slot sequence
	ch_code_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		ch[1:0] != 2'd3
	) else $error("channel code %0d is a gap code", ch);

endmodule

// handshake side, a pending write never targets a gap code
bind fm_bus_port fm_reg_assertions u_bus_checks (
	.clk(clk), .arst_n(arst_n), .req(req), .ack(ack),
	.ch(wr_pending ? wr_ch : 3'd0)
);

// sequencer side, no handshake here
bind fm_slot_counter fm_reg_assertions u_slot_checks (
	.clk(clk), .arst_n(arst_n), .req(1'b0), .ack(1'b0), .ch(cur_ch)
);

//--- sim/fm_reg_tb.sv
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_reg_tb
	import fm_bus_pkg::*;
	import fm_voice_pkg::*;
();

	// test length: 214 host writes, 15 checked frames
	localparam int N_WRITES = 214;
	localparam int N_FRAMES = 15;
	localparam int WATCH_CYCLES = 10 + N_WRITES * 30 + N_FRAMES * 60 + 100;

	logic        clk;
	logic        arst_n;
	logic        clk_en;
	logic        req;
	logic [7:0]  addr;
	logic        part;
	logic [7:0]  data;
	logic        ack;
	logic [2:0]  slot_ch, dt1, block, fb, pms;
	logic [1:0]  slot_op, ks, rl, ams;
	logic        frame_start, carrier, am;
	logic [3:0]  mul, d1l, rr;
	logic [6:0]  tl;
	logic [4:0]  ar, d1r, d2r;
	logic [10:0] fnum;
	alg_t        alg;

	// raw register bytes per group, by slot or by channel
	logic [7:0]  mdl [10][`FM_NUM_SLOTS];
	// block/fnum-high bytes not yet moved in
	logic [7:0]  lat [`FM_NUM_CH];
	logic [31:0] seed;
	logic [7:0]  a;
	logic [3:0]  row;
	int          errors;
	int          checks;
	int          tests;
	int          err0;
	int          nfs;
	int          idx;

	fm_reg_top DUT (
		.clk(clk), .arst_n(arst_n), .clk_en(clk_en), .req(req), .addr(addr),
		.part(part), .data(data), .ack(ack), .slot_ch(slot_ch), .slot_op(slot_op),
		.frame_start(frame_start), .carrier(carrier), .dt1(dt1), .mul(mul), .tl(tl),
		.ks(ks), .ar(ar), .am(am), .d1r(d1r), .d2r(d2r), .d1l(d1l), .rr(rr),
		.fnum(fnum), .block(block), .fb(fb), .alg(alg), .rl(rl), .ams(ams), .pms(pms)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// address row to group, as the host sees the map
	function automatic reg_group_e grp_of(input logic [7:0] ad);
		case (ad[7:4])
			4'h3: return GRP_DT_MUL;
			4'h4: return GRP_TL;
			4'h5: return GRP_KS_AR;
			4'h6: return GRP_AM_D1R;
			4'h7: return GRP_D2R;
			4'h8: return GRP_D1L_RR;
			4'hA: return (ad[3:2] == 2'd0) ? GRP_FNUM_LO :
				(ad[3:2] == 2'd1) ? GRP_BLK_FNHI : GRP_NONE;
			4'hB: return (ad[3:2] == 2'd0) ? GRP_FB_ALG :
				(ad[3:2] == 2'd1) ? GRP_LR_AMS_PMS : GRP_NONE;
			default: return GRP_NONE;
		endcase
	endfunction

	// stage of each operator row, slot order s1 s3 s2 s4
	function automatic op_stage_e stage_of_row(input int op);
		case (op)
			0: return S1;
			1: return S3;
			2: return S2;
			default: return S4;
		endcase
	endfunction

	// expected parameters of one slot, unpacked in port order
	function automatic logic [66:0] ref_slot(input int ch, input int op);
		int s;
		logic [7:0] dm, tlv, ka, ad, d2, dr, fl, bf, fa, lr;
		s = op * `FM_NUM_CH + ch;
		dm = mdl[GRP_DT_MUL][s];
		tlv = mdl[GRP_TL][s];
		ka = mdl[GRP_KS_AR][s];
		ad = mdl[GRP_AM_D1R][s];
		d2 = mdl[GRP_D2R][s];
		dr = mdl[GRP_D1L_RR][s];
		fl = mdl[GRP_FNUM_LO][ch];
		bf = mdl[GRP_BLK_FNHI][ch];
		fa = mdl[GRP_FB_ALG][ch];
		lr = mdl[GRP_LR_AMS_PMS][ch];
		return {dm[6:4], dm[3:0], tlv[6:0], ka[7:6], ka[4:0], ad[7], ad[4:0], d2[4:0],
			dr[7:4], dr[3:0], bf[2:0], fl, bf[5:3], fa[5:3], fa[2:0],
			lr[7:6], lr[5:4], lr[2:0]};
	endfunction

	// stages routed to the output per algorithm
	function automatic logic ref_carrier(input alg_t al, input op_stage_e st);
		case (al)
			3'd0, 3'd1, 3'd2, 3'd3: return st == S4;
			3'd4: return (st == S2) || (st == S4);
			3'd5, 3'd6: return st inside {S2, S3, S4};
			default: return 1'b1;
		endcase
	endfunction

	task automatic check_field(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_alg(input alg_t got, input alg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: alg got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_stage(input op_stage_e got, input op_stage_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: stage got %s (%0d) expected %s", $time,
				got.name(), got, exp.name());
		end
	endtask

	// committed write into the model bytes
	task automatic apply_model(input logic [7:0] ad, input logic p, input logic [7:0] d);
		reg_group_e g;
		int ch;
		g = grp_of(ad);
		ch = 3 * int'(p) + int'(ad[1:0]);
		if (g != GRP_NONE && ad[1:0] != 2'd3) begin
			if (g == GRP_BLK_FNHI)
				lat[ch] = d;
			else if (g == GRP_FNUM_LO) begin
				mdl[GRP_FNUM_LO][ch] = d;
				mdl[GRP_BLK_FNHI][ch] = lat[ch];
			end else if (g == GRP_FB_ALG || g == GRP_LR_AMS_PMS)
				mdl[g][ch] = d;
			else
				mdl[g][int'(ad[3:2]) * `FM_NUM_CH + ch] = d;
		end
	endtask

	// one four-phase write, latency bounded
	task automatic write_reg(input logic [7:0] ad, input logic p, input logic [7:0] d);
		int n;
		@(posedge clk);
		#2;
		addr = ad;
		part = p;
		data = d;
		req = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ack && n < 30);
		if (!ack) begin
			errors++;
			$display("no ack for write to %0h part %0d after %0d cycles", ad, p, n);
		end else if (n < 2 || n > 26) begin
			errors++;
			$display("ack latency %0d cycles for write to %0h is outside 2 to 26", n, ad);
		end
		apply_model(ad, p, d);
		@(posedge clk);
		#2;
		req = 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (ack && n < 3);
		if (ack || n > 1) begin
			errors++;
			$display("ack did not fall on the first clock after req fell, address %0h", ad);
		end
	endtask

	// 26 slots to settle, then n whole frames
	task automatic settle_frames(input int n);
		repeat (26 + `FM_NUM_SLOTS * n) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err0)
			$display("test %s done, no errors", name);
		else
			$display("test %s done, %0d errors", name, errors - err0);
		err0 = errors;
	endtask

	task automatic compare_slot(input int ix);
		int ch;
		int op;
		logic [2:0]  e_dt1, e_block, e_fb, e_pms;
		logic [3:0]  e_mul, e_d1l, e_rr;
		logic [6:0]  e_tl;
		logic [1:0]  e_ks, e_rl, e_ams;
		logic [4:0]  e_ar, e_d1r, e_d2r;
		logic        e_am;
		logic [10:0] e_fnum;
		alg_t        e_alg;
		op = ix / `FM_NUM_CH;
		ch = ix % `FM_NUM_CH;
		{e_dt1, e_mul, e_tl, e_ks, e_ar, e_am, e_d1r, e_d2r, e_d1l, e_rr,
			e_fnum, e_block, e_fb, e_alg, e_rl, e_ams, e_pms} = ref_slot(ch, op);
		check_field("slot_ch", slot_ch, 8'(ch));
		check_field("slot_op", slot_op, 8'(op));
		check_field("frame_start", frame_start, 8'(ix == 0));
		// sequencer already sits on the slot after the presented one
		check_stage(DUT.u_slot_counter.stage,
			stage_of_row(((ix + 1) % `FM_NUM_SLOTS) / `FM_NUM_CH));
		check_field("carrier", carrier, ref_carrier(e_alg, stage_of_row(op)));
		check_field("dt1", dt1, e_dt1);
		check_field("mul", mul, e_mul);
		check_field("tl", tl, e_tl);
		check_field("ks", ks, e_ks);
		check_field("ar", ar, e_ar);
		check_field("am", am, e_am);
		check_field("d1r", d1r, e_d1r);
		check_field("d2r", d2r, e_d2r);
		check_field("d1l", d1l, e_d1l);
		check_field("rr", rr, e_rr);
		check_field("fnum_lo", fnum[7:0], e_fnum[7:0]);
		check_field("fnum_hi", fnum[10:8], e_fnum[10:8]);
		check_field("block", block, e_block);
		check_field("fb", fb, e_fb);
		check_alg(alg, e_alg);
		check_field("rl", rl, e_rl);
		check_field("ams", ams, e_ams);
		check_field("pms", pms, e_pms);
	endtask

	// every presented slot, sampled mid-cycle
	initial begin
		idx = 0;
		@(posedge arst_n);
		@(posedge clk);
		forever begin
			@(negedge clk);
			compare_slot(idx);
			idx = (idx + 1) % `FM_NUM_SLOTS;
		end
	end

	initial begin
		#(WATCH_CYCLES * 40);
		$display("watchdog expired after %0d cycles", WATCH_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		clk_en = 1'b1;
		req = 1'b0;
		addr = 8'd0;
		part = 1'b0;
		data = 8'd0;
		seed = 32'd5548;
		errors = 0;
		checks = 0;
		tests = 0;
		err0 = 0;
		// reset image of the register map
		for (int g = 0; g < 10; g++)
			for (int s = 0; s < `FM_NUM_SLOTS; s++)
				mdl[g][s] = 8'd0;
		for (int s = 0; s < `FM_NUM_SLOTS; s++)
			mdl[GRP_TL][s] = {1'b0, `FM_TL_RESET};
		for (int c = 0; c < `FM_NUM_CH; c++) begin
			mdl[GRP_LR_AMS_PMS][c] = {`FM_RL_RESET, 6'd0};
			lat[c] = 8'd0;
		end
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;

		settle_frames(1);
		end_test("reset_values");

		// two frames, two frame starts
		nfs = 0;
		repeat (2 * `FM_NUM_SLOTS) begin
			@(posedge clk);
			#1;
			if (frame_start)
				nfs++;
		end
		if (nfs != 2) begin
			errors++;
			$display("saw %0d frame starts in two frames, expected 2", nfs);
		end
		end_test("slot_order");

		// operator rows 0x30 to 0x80, valid channel fields only
		for (int i = 0; i < 200; i++) begin
			seed = lcg_next(seed);
			row = 4'(3 + seed[31:16] % 6);
			a = {row, seed[13:12], 2'(seed[9:8] % 3)};
			seed = lcg_next(seed);
			write_reg(a, seed[30], seed[23:16]);
		end
		settle_frames(1);
		end_test("op_writes");

		// block 5, fnum high 5 on channel 2
		write_reg(8'hA6, 1'b0, 8'h2D);
		settle_frames(1);
		write_reg(8'hA2, 1'b0, 8'h9C);
		settle_frames(1);
		end_test("fnum_latch");

		// every algorithm on channel 4
		for (int k = 0; k < 8; k++) begin
			write_reg(8'hB1, 1'b1, 8'(k));
			settle_frames(1);
		end
		end_test("carrier");

		// channel field 3, ssg-eg row, ch3 special row
		write_reg(8'h43, 1'b0, 8'h55);
		write_reg(8'h47, 1'b1, 8'h55);
		write_reg(8'h92, 1'b0, 8'h55);
		write_reg(8'hA8, 1'b0, 8'h55);
		settle_frames(1);
		end_test("invalid_writes");

		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+design
design/fm_bus_pkg.sv
design/fm_voice_pkg.sv
design/fm_bus_port.sv
design/fm_slot_counter.sv
design/fm_op_regs.sv
design/fm_ch_regs.sv
design/fm_slot_out.sv
design/fm_reg_top.sv
sim/fm_reg_assertions.sv
sim/fm_reg_tb.sv
